// File: compile.f
+incdir+include
hdl/lfdb_store_pkg.sv
hdl/lfdb_cmd_pkg.sv
hdl/lfdb_data_ram.sv
hdl/lfdb_mem_arbiter.sv
hdl/lfdb_fill_writer.sv
hdl/lfdb_drain_reader.sv
hdl/lfdb_entry_tracker.sv
hdl/lfdb_agent.sv
sim/tb_lfdb_agent.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the linefill buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_lfdb_agent -o tb_lfdb_agent || exit 1

out=$(./obj_dir/tb_lfdb_agent)
echo "$out"

echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1

// File: sim/tb_lfdb_agent.sv
`timescale 1ns/1ps

`include "lfdb_params.svh"

module tb_lfdb_agent;

    import lfdb_store_pkg::*;
    import lfdb_cmd_pkg::*;

    localparam int N          = `LFDB_ENTRY_NUM;
    localparam int A_DLY      = `ARB_TO_LFDB_DELAY;
    localparam int D_DLY      = `LF_DONE_DELAY;
    localparam int WAIT_LIMIT = 200;
    localparam int MAX_CYCLES = 3000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       drain_vld;
    drain_req_t drain_req;
    logic       drain_rdy;
    logic       fill_vld;
    fill_beat_t fill_beat;
    logic       fill_rdy;
    logic       alloc_vld;
    entry_id_t  alloc_idx;
    logic       alloc_rdy;
    logic       ram_vld;
    ram_write_t ram_wr;
    logic       fill_done;
    rob_id_t    fill_done_rob;
    entry_id_t  fill_done_entry;
    logic       linefill_done;
    rob_id_t    linefill_done_rob;

    integer     seed = 32'h2661_de5f;
    int         errors = 0;
    int         timeouts = 0;

    // reference model state
    int         cyc;
    logic [N-1:0] idle_m;
    logic [N-1:0] filled_m;
    int         fill_cnt;
    beat_data_t model_mem [N][`LFDB_BEAT_NUM];
    int         acc_cyc [$];     // edge of each accepted drain
    drain_req_t acc_req [$];

    // expected outputs for the next sampling edge
    logic       exp_alloc_vld;
    entry_id_t  exp_alloc_idx;
    logic       exp_drain_rdy;
    logic       exp_fill_rdy;
    logic       exp_ram_vld;
    ram_write_t exp_ram_wr;
    logic       exp_lf_done;
    rob_id_t    exp_lf_rob;

    always #10 clk = ~clk;

    lfdb_agent i_lfdb_agent (.*);

    // ====================
    // reference model
    // ====================

    function automatic entry_id_t lowest_idle(input logic [N-1:0] v);
        entry_id_t idx;
        logic      found;
        idx   = '0;
        found = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (v[i] && !found) begin
                idx   = entry_id_t'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        int         d;
        int         b;
        entry_id_t  e;
        logic       nxt_rdy;
        logic       nxt_fill_rdy;
        logic       nxt_ram_vld;
        ram_write_t nxt_wr;
        logic       nxt_lf;
        rob_id_t    nxt_lf_rob;
        if (!rst_n) begin
            cyc      = 0;
            idle_m   = '1;
            filled_m = '0;
            fill_cnt = 0;
            acc_cyc.delete();
            acc_req.delete();
            exp_alloc_vld <= 1'b0;
            exp_alloc_idx <= '0;
            exp_drain_rdy <= 1'b0;
            exp_fill_rdy  <= 1'b1;
            exp_ram_vld   <= 1'b0;
            exp_ram_wr    <= '0;
            exp_lf_done   <= 1'b0;
            exp_lf_rob    <= '0;
        end else begin
            cyc = cyc + 1;
            if (alloc_rdy && exp_alloc_vld) begin
                idle_m[exp_alloc_idx] = 1'b0;
            end
            // entry released on the edge after its last read
            foreach (acc_cyc[i]) begin
                e = acc_req[i].entry_id;
                if (cyc - acc_cyc[i] == A_DLY + 3 && filled_m[e]) begin
                    idle_m[e]   = 1'b1;
                    filled_m[e] = 1'b0;
                end
            end
            if (fill_vld && exp_fill_rdy) begin
                model_mem[fill_beat.entry_id][fill_cnt] = fill_beat.data;
                if (fill_beat.last) begin
                    fill_cnt = 0;
                    filled_m[fill_beat.entry_id] = 1'b1;
                end else begin
                    fill_cnt = fill_cnt + 1;
                end
            end
            if (drain_vld && exp_drain_rdy) begin
                acc_cyc.push_back(cyc);
                acc_req.push_back(drain_req);
            end
            while (acc_cyc.size() > 0 && cyc - acc_cyc[0] >= D_DLY) begin
                void'(acc_cyc.pop_front());
                void'(acc_req.pop_front());
            end

            nxt_rdy      = 1'b1;
            nxt_fill_rdy = 1'b1;
            nxt_ram_vld  = 1'b0;
            nxt_wr       = '0;
            nxt_lf       = 1'b0;
            nxt_lf_rob   = '0;
            foreach (acc_cyc[i]) begin
                d = cyc + 1 - acc_cyc[i];
                if (d >= 1 && d <= 3) nxt_rdy = 1'b0;
                if (d >= A_DLY && d <= A_DLY + 4) nxt_fill_rdy = 1'b0;  // reads plus one
                if (d >= A_DLY + 1 && d <= A_DLY + 4) begin
                    b = d - A_DLY - 1;
                    nxt_ram_vld      = 1'b1;
                    nxt_wr.rob_id    = acc_req[i].rob_id;
                    nxt_wr.ram_id    = acc_req[i].ram_id;
                    nxt_wr.line_addr = acc_req[i].line_addr;
                    nxt_wr.beat_idx  = beat_idx_t'(b);
                    nxt_wr.last      = (b == `LFDB_BEAT_NUM - 1);
                    nxt_wr.data      = model_mem[acc_req[i].entry_id][b];
                end
                if (d == D_DLY) begin
                    nxt_lf     = 1'b1;
                    nxt_lf_rob = acc_req[i].rob_id;
                end
            end
            exp_drain_rdy <= nxt_rdy;
            exp_fill_rdy  <= nxt_fill_rdy;
            exp_ram_vld   <= nxt_ram_vld;
            exp_ram_wr    <= nxt_wr;
            exp_lf_done   <= nxt_lf;
            exp_lf_rob    <= nxt_lf_rob;
            exp_alloc_vld <= |idle_m;
            exp_alloc_idx <= lowest_idle(idle_m);
        end
    end

    // ====================
    // assertions
    // ====================

    a_alloc_vld: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_vld == exp_alloc_vld) else report_fail("alloc_vld mismatch");
    a_alloc_idx: assert property (@(posedge clk) disable iff (!rst_n)
        exp_alloc_vld |-> alloc_idx == exp_alloc_idx) else report_fail("alloc_idx mismatch");
    a_drain_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        drain_rdy == exp_drain_rdy) else report_fail("drain_rdy mismatch");
    a_fill_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        fill_rdy == exp_fill_rdy) else report_fail("fill_rdy mismatch");
    a_fill_done: assert property (@(posedge clk) disable iff (!rst_n)
        fill_done == (fill_vld && exp_fill_rdy && fill_beat.last))
        else report_fail("fill_done mismatch");
    a_fill_tags: assert property (@(posedge clk) disable iff (!rst_n)
        fill_done |-> (fill_done_rob == fill_beat.rob_id
                       && fill_done_entry == fill_beat.entry_id))
        else report_fail("fill_done tags mismatch");
    a_ram_vld: assert property (@(posedge clk) disable iff (!rst_n)
        ram_vld == exp_ram_vld) else report_fail("ram_vld mismatch");
    a_ram_wr: assert property (@(posedge clk) disable iff (!rst_n)
        exp_ram_vld |-> ram_wr == exp_ram_wr) else report_fail("ram_wr mismatch");
    a_lf_done: assert property (@(posedge clk) disable iff (!rst_n)
        linefill_done == exp_lf_done) else report_fail("linefill_done mismatch");
    a_lf_rob: assert property (@(posedge clk) disable iff (!rst_n)
        exp_lf_done |-> linefill_done_rob == exp_lf_rob)
        else report_fail("linefill_done_rob mismatch");

    // ====================
    // tasks
    // ====================

    task automatic report_fail(input string what);
        errors++;
        $display("[FAIL] %0t %s", $time, what);
    endtask

    task automatic finish_run();
        $display("checks done, errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) @(negedge clk);
    endtask

    task automatic take_alloc();
        int waited;
        waited = 0;
        while (!alloc_vld && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!alloc_vld) give_up("alloc_vld");
        alloc_rdy = 1'b1;
        @(negedge clk);
        alloc_rdy = 1'b0;
    endtask

    task automatic send_fill(input rob_id_t rob, input entry_id_t ent,
                             input logic last, input beat_data_t data);
        int waited;
        waited             = 0;
        fill_beat.rob_id   = rob;
        fill_beat.entry_id = ent;
        fill_beat.last     = last;
        fill_beat.data     = data;
        fill_vld           = 1'b1;
        while (!fill_rdy && waited < WAIT_LIMIT) begin   // held while the reader runs
            @(negedge clk);
            waited++;
        end
        if (!fill_rdy) give_up("fill_rdy");
        @(negedge clk);
        fill_vld = 1'b0;
    endtask

    task automatic fill_line(input rob_id_t rob, input entry_id_t ent);
        beat_data_t data;
        for (int b = 0; b < `LFDB_BEAT_NUM; b++) begin
            data = {$random(seed), $random(seed)};
            send_fill(rob, ent, b == `LFDB_BEAT_NUM - 1, data);
        end
    endtask

    task automatic send_drain(input entry_id_t ent, input rob_id_t rob);
        logic [31:0] r;
        int          waited;
        r                  = $random(seed);
        waited             = 0;
        drain_req.rob_id    = rob;
        drain_req.entry_id  = ent;
        drain_req.ram_id    = ram_id_t'(ent);
        drain_req.line_addr = r[`LINE_ADDR_WIDTH-1:0];
        drain_vld          = 1'b1;
        while (!drain_rdy && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!drain_rdy) give_up("drain_rdy");
        @(negedge clk);
        drain_vld = 1'b0;
    endtask

    task automatic wait_drains_idle();
        int waited;
        waited = 0;
        while (acc_cyc.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (acc_cyc.size() != 0) give_up("drain bursts to finish");
    endtask

    // ====================
    // stimulus
    // ====================

    initial begin
        rst_n     = 1'b0;
        drain_vld = 1'b0;
        drain_req = '0;
        fill_vld  = 1'b0;
        fill_beat = '0;
        alloc_rdy = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(2);

        for (int i = 0; i < N; i++) take_alloc();   // ends with alloc_vld low
        idle_cycles(3);
        for (int i = 0; i < 4; i++) fill_line(rob_id_t'(i + 1), entry_id_t'(i));

        send_drain(entry_id_t'(0), rob_id_t'(9));
        wait_drains_idle();

        // overlapping drains with a fill held off by the reads
        fork
            begin
                send_drain(entry_id_t'(1), rob_id_t'(10));
                send_drain(entry_id_t'(2), rob_id_t'(11));
            end
            begin
                idle_cycles(3);
                fill_line(rob_id_t'(5), entry_id_t'(4));
            end
        join
        wait_drains_idle();

        send_drain(entry_id_t'(4), rob_id_t'(12));
        send_drain(entry_id_t'(3), rob_id_t'(13));
        wait_drains_idle();

        // released entries come back lowest first
        take_alloc();
        take_alloc();
        take_alloc();
        idle_cycles(4);
        finish_run();
    end

    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) @(posedge clk);
        give_up("the test to end within its cycle limit");
    end

endmodule

// File: hdl/lfdb_agent.sv
`timescale 1ns/1ps

module lfdb_agent (
    input  logic                      clk,
    input  logic                      rst_n,

    // drain requests
    input  logic                      drain_vld,
    input  lfdb_cmd_pkg::drain_req_t  drain_req,
    output logic                      drain_rdy,

    // downstream linefill beats
    input  logic                      fill_vld,
    input  lfdb_cmd_pkg::fill_beat_t  fill_beat,
    output logic                      fill_rdy,

    // entry pre-allocation
    output logic                      alloc_vld,
    output lfdb_store_pkg::entry_id_t alloc_idx,
    input  logic                      alloc_rdy,

    // destination RAM writes
    output logic                      ram_vld,
    output lfdb_cmd_pkg::ram_write_t  ram_wr,

    output logic                      fill_done,
    output lfdb_cmd_pkg::rob_id_t     fill_done_rob,
    output lfdb_store_pkg::entry_id_t fill_done_entry,
    output logic                      linefill_done,
    output lfdb_cmd_pkg::rob_id_t     linefill_done_rob
);

    import lfdb_store_pkg::*;
    import lfdb_cmd_pkg::*;

    logic       fill_gnt;
    mem_req_t   fill_req;
    mem_req_t   mem_req;
    logic       drain_req_en;
    db_addr_t   drain_addr;
    beat_data_t rd_data;
    logic       filled_vld;
    entry_id_t  filled_entry;
    logic       release_vld;
    entry_id_t  release_entry;

    lfdb_entry_tracker i_lfdb_entry_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_vld     (alloc_vld),
        .alloc_idx     (alloc_idx),
        .alloc_rdy     (alloc_rdy),
        .filled_vld    (filled_vld),
        .filled_entry  (filled_entry),
        .release_vld   (release_vld),
        .release_entry (release_entry)
    );

    lfdb_fill_writer i_lfdb_fill_writer (
        .clk             (clk),
        .rst_n           (rst_n),
        .fill_vld        (fill_vld),
        .fill_beat       (fill_beat),
        .fill_rdy        (fill_rdy),
        .fill_gnt        (fill_gnt),
        .fill_req        (fill_req),
        .fill_done       (fill_done),
        .fill_done_rob   (fill_done_rob),
        .fill_done_entry (fill_done_entry),
        .filled_vld      (filled_vld),
        .filled_entry    (filled_entry)
    );

    lfdb_drain_reader i_lfdb_drain_reader (
        .clk               (clk),
        .rst_n             (rst_n),
        .drain_vld         (drain_vld),
        .drain_req         (drain_req),
        .drain_rdy         (drain_rdy),
        .drain_req_en      (drain_req_en),
        .drain_addr        (drain_addr),
        .rd_data           (rd_data),
        .ram_vld           (ram_vld),
        .ram_wr            (ram_wr),
        .linefill_done     (linefill_done),
        .linefill_done_rob (linefill_done_rob),
        .release_vld       (release_vld),
        .release_entry     (release_entry)
    );

    // ====================
    // shared buffer RAM
    // ====================

    lfdb_mem_arbiter i_lfdb_mem_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill_req     (fill_req),
        .drain_req_en (drain_req_en),
        .drain_addr   (drain_addr),
        .fill_gnt     (fill_gnt),
        .mem_req      (mem_req)
    );

    lfdb_data_ram i_lfdb_data_ram (
        .clk     (clk),
        .mem_req (mem_req),
        .rd_data (rd_data)
    );

endmodule

// File: hdl/lfdb_entry_tracker.sv
`timescale 1ns/1ps

`include "lfdb_params.svh"

module lfdb_entry_tracker (
    input  logic                      clk,
    input  logic                      rst_n,

    output logic                      alloc_vld,
    output lfdb_store_pkg::entry_id_t alloc_idx,
    input  logic                      alloc_rdy,

    input  logic                      filled_vld,
    input  lfdb_store_pkg::entry_id_t filled_entry,

    input  logic                      release_vld,
    input  lfdb_store_pkg::entry_id_t release_entry
);

    import lfdb_store_pkg::*;

    localparam int N = `LFDB_ENTRY_NUM;

    logic [N-1:0] idle_q;
    logic [N-1:0] idle_d;
    logic [N-1:0] filled_q;
    entry_id_t    low_idx;

    always_comb begin
        idle_d = idle_q;
        if (alloc_vld && alloc_rdy) begin
            idle_d[alloc_idx] = 1'b0;           // reserved
        end
        if (release_vld && filled_q[release_entry]) begin
            idle_d[release_entry] = 1'b1;
        end
    end

    // lowest idle entry of the next state
    always_comb begin
        low_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (idle_d[i]) begin
                low_idx = entry_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_q    <= '1;
            filled_q  <= '0;
            alloc_vld <= 1'b0;
            alloc_idx <= '0;
        end else begin
            idle_q    <= idle_d;
            alloc_vld <= |idle_d;
            alloc_idx <= low_idx;
            if (release_vld && filled_q[release_entry]) begin
                filled_q[release_entry] <= 1'b0;
            end
            if (filled_vld) begin
                filled_q[filled_entry] <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/lfdb_drain_reader.sv
`timescale 1ns/1ps

`include "lfdb_params.svh"

module lfdb_drain_reader (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       drain_vld,
    input  lfdb_cmd_pkg::drain_req_t   drain_req,
    output logic                       drain_rdy,

    output logic                       drain_req_en,
    output lfdb_store_pkg::db_addr_t   drain_addr,
    input  lfdb_store_pkg::beat_data_t rd_data,

    output logic                       ram_vld,
    output lfdb_cmd_pkg::ram_write_t   ram_wr,

    output logic                       linefill_done,
    output lfdb_cmd_pkg::rob_id_t      linefill_done_rob,

    output logic                       release_vld,
    output lfdb_store_pkg::entry_id_t  release_entry
);

    import lfdb_store_pkg::*;
    import lfdb_cmd_pkg::*;

    localparam int        PIPE_LEN    = `LF_DONE_DELAY;
    localparam int        START_STAGE = `ARB_TO_LFDB_DELAY - 2;   // burst starts next edge
    localparam beat_idx_t LAST_BEAT   = beat_idx_t'(`LFDB_BEAT_NUM - 1);

    logic [PIPE_LEN-1:0] vld_pipe;
    drain_req_t          pay_pipe [PIPE_LEN];
    logic                req_acc;
    logic                rdy_q;

    logic                busy;      // burst in progress
    beat_idx_t           beat_cnt;
    drain_req_t          cur_req;

    logic                out_vld_q;
    drain_req_t          out_req_q;
    beat_idx_t           out_beat_q;
    logic                out_last_q;

    assign req_acc   = drain_vld && drain_rdy;
    assign drain_rdy = rdy_q;

    // ====================
    // request delay pipe
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
            rdy_q    <= 1'b0;
        end else begin
            vld_pipe <= {vld_pipe[PIPE_LEN-2:0], req_acc};
            rdy_q    <= !(req_acc || vld_pipe[0] || vld_pipe[1]);   // 3 cycles low
        end
    end

    always_ff @(posedge clk) begin
        pay_pipe[0] <= drain_req;
        for (int i = 1; i < PIPE_LEN; i++) begin
            pay_pipe[i] <= pay_pipe[i-1];
        end
    end

    // ====================
    // burst sequencer
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
        end else if (vld_pipe[START_STAGE]) begin
            busy     <= 1'b1;
            beat_cnt <= '0;
        end else if (busy) begin
            if (beat_cnt == LAST_BEAT) begin
                busy <= 1'b0;
            end
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (vld_pipe[START_STAGE]) begin
            cur_req <= pay_pipe[START_STAGE];
        end
    end

    assign drain_req_en  = busy;
    assign drain_addr    = {cur_req.entry_id, beat_cnt};
    assign release_vld   = busy && (beat_cnt == LAST_BEAT);
    assign release_entry = cur_req.entry_id;

    // command delayed to meet the RAM read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld_q <= 1'b0;
        end else begin
            out_vld_q <= busy;
        end
    end

    always_ff @(posedge clk) begin
        out_req_q  <= cur_req;
        out_beat_q <= beat_cnt;
        out_last_q <= (beat_cnt == LAST_BEAT);
    end

    assign ram_vld = out_vld_q;
    assign ram_wr  = '{rob_id:    out_req_q.rob_id,
                       ram_id:    out_req_q.ram_id,
                       line_addr: out_req_q.line_addr,
                       beat_idx:  out_beat_q,
                       last:      out_last_q,
                       data:      rd_data};

    assign linefill_done     = vld_pipe[PIPE_LEN-1];
    assign linefill_done_rob = pay_pipe[PIPE_LEN-1].rob_id;

endmodule

// File: hdl/lfdb_fill_writer.sv
`timescale 1ns/1ps

module lfdb_fill_writer (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      fill_vld,
    input  lfdb_cmd_pkg::fill_beat_t  fill_beat,
    output logic                      fill_rdy,

    input  logic                      fill_gnt,
    output lfdb_cmd_pkg::mem_req_t    fill_req,

    output logic                      fill_done,
    output lfdb_cmd_pkg::rob_id_t     fill_done_rob,
    output lfdb_store_pkg::entry_id_t fill_done_entry,

    output logic                      filled_vld,
    output lfdb_store_pkg::entry_id_t filled_entry
);

    import lfdb_store_pkg::*;

    beat_idx_t beat_cnt;
    logic      beat_acc;
    logic      line_end;

    assign fill_rdy = fill_gnt;     // held off while the reader owns the RAM
    assign beat_acc = fill_vld && fill_rdy;
    assign line_end = beat_acc && fill_beat.last;

    // beats accepted so far in the current line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (line_end) begin
            beat_cnt <= '0;
        end else if (beat_acc) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // write request, granted by the arbiter
    assign fill_req.en    = fill_vld;
    assign fill_req.we    = 1'b1;
    assign fill_req.addr  = {fill_beat.entry_id, beat_cnt};
    assign fill_req.wdata = fill_beat.data;

    // ====================
    // done pulses
    // ====================

    assign fill_done       = line_end;
    assign fill_done_rob   = fill_beat.rob_id;
    assign fill_done_entry = fill_beat.entry_id;

    assign filled_vld   = line_end;    // tracker marks the entry filled
    assign filled_entry = fill_beat.entry_id;

endmodule

// File: hdl/lfdb_mem_arbiter.sv
`timescale 1ns/1ps

module lfdb_mem_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  lfdb_cmd_pkg::mem_req_t   fill_req,
    input  logic                     drain_req_en,
    input  lfdb_store_pkg::db_addr_t drain_addr,
    output logic                     fill_gnt,
    output lfdb_cmd_pkg::mem_req_t   mem_req
);

    import lfdb_store_pkg::*;

    arb_state_e state_q;

    // reads win and fill waits one extra cycle after a burst
    assign fill_gnt = !drain_req_en && (state_q != ARB_DRAIN);

    always_comb begin
        mem_req.wdata = fill_req.wdata;     // ignored on a read
        if (drain_req_en) begin
            mem_req.en   = 1'b1;
            mem_req.we   = 1'b0;
            mem_req.addr = drain_addr;
        end else begin
            mem_req.en   = fill_req.en && fill_gnt;
            mem_req.we   = fill_req.we;
            mem_req.addr = fill_req.addr;
        end
    end

    // ====================
    // last grant
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ARB_IDLE;
        end else if (drain_req_en) begin
            state_q <= ARB_DRAIN;
        end else if (fill_req.en && fill_gnt) begin
            state_q <= ARB_FILL;
        end else begin
            state_q <= ARB_IDLE;
        end
    end

endmodule

// File: hdl/lfdb_data_ram.sv
`timescale 1ns/1ps

`include "lfdb_params.svh"

module lfdb_data_ram (
    input  logic                       clk,
    input  lfdb_cmd_pkg::mem_req_t     mem_req,
    output lfdb_store_pkg::beat_data_t rd_data
);

    import lfdb_store_pkg::*;

    localparam int DEPTH = `LFDB_ENTRY_NUM * `LFDB_BEAT_NUM;   // 32 words

    beat_data_t mem [0:DEPTH-1];

    // single port, write or registered read
    always_ff @(posedge clk) begin
        if (mem_req.en) begin
            if (mem_req.we) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rd_data <= mem[mem_req.addr];   // one cycle latency
            end
        end
    end

endmodule

// File: hdl/lfdb_cmd_pkg.sv
`include "lfdb_params.svh"

package lfdb_cmd_pkg;

    // ====================
    // tags
    // ====================

    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [`RAM_ID_WIDTH-1:0] ram_id_t;

    // ====================
    // external commands
    // ====================

    // delayed read of one buffered line
    typedef struct packed {
        rob_id_t                    rob_id;
        lfdb_store_pkg::entry_id_t  entry_id;
        ram_id_t                    ram_id;     // destination RAM
        logic [`LINE_ADDR_WIDTH-1:0] line_addr;
    } drain_req_t;

    // one downstream data beat
    typedef struct packed {
        rob_id_t                    rob_id;
        lfdb_store_pkg::entry_id_t  entry_id;
        logic                       last;       // beat 3 of the line
        lfdb_store_pkg::beat_data_t data;
    } fill_beat_t;

    // beat written into the destination RAM
    typedef struct packed {
        rob_id_t                    rob_id;
        ram_id_t                    ram_id;
        logic [`LINE_ADDR_WIDTH-1:0] line_addr;
        lfdb_store_pkg::beat_idx_t  beat_idx;
        logic                       last;
        lfdb_store_pkg::beat_data_t data;
    } ram_write_t;

    // ====================
    // buffer RAM port
    // ====================

    typedef struct packed {
        logic                       en;
        logic                       we;         // low for a read
        lfdb_store_pkg::db_addr_t   addr;
        lfdb_store_pkg::beat_data_t wdata;
    } mem_req_t;

endpackage

// File: hdl/lfdb_store_pkg.sv
`include "lfdb_params.svh"

package lfdb_store_pkg;

    // ====================
    // storage indices
    // ====================

    // one line entry of the buffer
    typedef logic [$clog2(`LFDB_ENTRY_NUM)-1:0] entry_id_t;

    // beat number inside a line
    typedef logic [$clog2(`LFDB_BEAT_NUM)-1:0] beat_idx_t;

    // RAM word address, entry id on top and beat index below
    typedef logic [$clog2(`LFDB_ENTRY_NUM)+$clog2(`LFDB_BEAT_NUM)-1:0] db_addr_t;

    // ====================
    // storage data
    // ====================

    typedef logic [`LFDB_BEAT_WIDTH-1:0] beat_data_t;

    // owner of the RAM port in the last cycle
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_FILL  = 2'd1,   // fill writer had the port
        ARB_DRAIN = 2'd2    // drain reader had the port
    } arb_state_e;

endpackage

// File: include/lfdb_params.svh
`ifndef LFDB_PARAMS_SVH
`define LFDB_PARAMS_SVH

// ====================
// buffer geometry
// ====================

`define LFDB_ENTRY_NUM      8       // line entries in the buffer
`define LFDB_BEAT_NUM       4       // beats per cache line
`define LFDB_BEAT_WIDTH     64      // bits per beat

// ====================
// tag widths
// ====================

`define ROB_ID_WIDTH        4
`define RAM_ID_WIDTH        2
`define LINE_ADDR_WIDTH     10      // line address in the destination RAM

// ====================
// drain timing
// ====================

// accept of a drain request to its first buffer read
`define ARB_TO_LFDB_DELAY   5

// accept to linefill done, one cycle past the last RAM beat
`define LF_DONE_DELAY       (`ARB_TO_LFDB_DELAY + 5)

`endif
